// File: design/dm_pkg.sv
/*
  Shared types, port widths, register addresses, the dminfo word and the
  debug ROM image of the debug module. Referenced by scoped name only.
*/
`default_nettype none

package dm_pkg;

  // Debug bus operation codes
  typedef enum logic [1:0] {
    DBUS_NOP   = 2'd0,
    DBUS_READ  = 2'd1,
    DBUS_WRITE = 2'd2,
    DBUS_RSVD  = 2'd3
  } dbus_op_e;

  // Port widths
  localparam int DBUS_ADDR_W = 5;
  localparam int DBUS_DATA_W = 34;
  localparam int SYS_ADDR_W  = 12;
  localparam int SYS_DATA_W  = 32;

  // Debug RAM geometry
  localparam int RAM_WORDS  = 7;
  localparam int RAM_ADDR_W = 3;

  // Debug bus register map, RAM words sit at 0x00..0x06
  localparam logic [DBUS_ADDR_W-1:0] DMCONTROL_ADDR = 5'h10;
  localparam logic [DBUS_ADDR_W-1:0] DMINFO_ADDR    = 5'h11;
  localparam logic [DBUS_ADDR_W-1:0] HALTSUM_ADDR   = 5'h1C;

  // System bus register map and pages (address bits 11:8)
  localparam logic [SYS_ADDR_W-1:0] CLEARDEBINT_ADDR = 12'h100;
  localparam logic [SYS_ADDR_W-1:0] SETHALTNOT_ADDR  = 12'h10C;
  localparam logic [3:0]            RAM_PAGE         = 4'h4;
  localparam logic [3:0]            ROM_PAGE         = 4'h8;

  // dramsize 6, authenticated, version 1
  localparam logic [DBUS_DATA_W-1:0] DMINFO_VALUE = 34'h0_0000_1821;

  // Park loop: save s0, report hart id to cleardebint, restore, return
  localparam logic [SYS_DATA_W-1:0] DEBUG_ROM [32] = '{
    32'h7b241073, 32'hf1402473, 32'h10802023, 32'h7b202473,
    32'h0000100f, 32'h7b200073, 32'h0000006f, 32'h00100073,
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0,
    32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0, 32'h0
  };

endpackage

`default_nettype wire

// File: design/dm_dbus_slave.sv
/*
  Debug bus slave. Decodes debugger requests, keeps the selected hart and
  answers in the same cycle; raises flag strobes on dmcontrol or RAM writes.
*/
`timescale 1ns/1ns
`default_nettype none

module dm_dbus_slave #(
  parameter int HART_NUM  = 1,
  parameter int HART_ID_W = 1
) (
  input  wire                          i_clk,
  input  wire                          i_reset,
  input  wire                          i_dbus_req_valid,
  input  wire [dm_pkg::DBUS_ADDR_W-1:0] i_dbus_req_addr,
  input  wire [dm_pkg::DBUS_DATA_W-1:0] i_dbus_req_data,
  input  wire [1:0]                    i_dbus_req_op,
  input  wire                          i_dbus_resp_ready,
  input  wire                          i_sys_ram_access,
  input  wire [dm_pkg::SYS_DATA_W-1:0] i_ram_rdata,
  input  wire [HART_NUM-1:0]           i_haltnot,
  input  wire [HART_NUM-1:0]           i_debint,
  output logic                         o_dbus_req_ready,
  output logic                         o_dbus_resp_valid,
  output logic [dm_pkg::DBUS_DATA_W-1:0] o_dbus_resp_data,
  output logic                         o_ram_access,
  output logic [dm_pkg::RAM_ADDR_W-1:0] o_ram_addr,
  output logic                         o_ram_read,
  output logic [dm_pkg::SYS_DATA_W-1:0] o_ram_wdata,
  output logic [HART_NUM-1:0]          o_haltnot_clr,
  output logic [HART_NUM-1:0]          o_debint_set
);

  dm_pkg::dbus_op_e         req_op;
  logic                     sel_ram;
  logic                     req_condi;
  logic                     req_hsk;
  logic                     wr_flags;
  logic [HART_ID_W-1:0]     hart_id;
  logic [2**HART_ID_W-1:0]  haltnot_ext;
  logic [2**HART_ID_W-1:0]  debint_ext;
  logic                     sel_haltnot;
  logic                     sel_debint;

  assign req_op  = dm_pkg::dbus_op_e'(i_dbus_req_op);
  assign sel_ram = (i_dbus_req_addr < dm_pkg::DBUS_ADDR_W'(dm_pkg::RAM_WORDS));

  // ==========================================================
  // Handshake, stalled while the system bus owns the RAM
  // ==========================================================
  assign req_condi         = sel_ram ? ~i_sys_ram_access : 1'b1;
  assign o_dbus_req_ready  = req_condi & i_dbus_resp_ready;
  assign o_dbus_resp_valid = req_condi & i_dbus_req_valid;
  assign req_hsk           = i_dbus_req_valid & o_dbus_req_ready;

  // Selected hart register
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      hart_id <= '0;
    end else if (req_hsk && req_op == dm_pkg::DBUS_WRITE &&
                 i_dbus_req_addr == dm_pkg::DMCONTROL_ADDR) begin
      hart_id <= i_dbus_req_data[HART_ID_W+1:2];
    end
  end

  // Pad flag vectors so any hart id indexes safely
  assign haltnot_ext = (2**HART_ID_W)'(i_haltnot);
  assign debint_ext  = (2**HART_ID_W)'(i_debint);
  assign sel_haltnot = haltnot_ext[hart_id];
  assign sel_debint  = debint_ext[hart_id];

  // Response data
  always_comb begin
    if (sel_ram) begin
      o_dbus_resp_data = {sel_debint, sel_haltnot, i_ram_rdata};
    end else begin
      case (i_dbus_req_addr)
        dm_pkg::DMCONTROL_ADDR:
          o_dbus_resp_data = {sel_debint, sel_haltnot, 20'b0, 10'(hart_id), 2'b0};
        dm_pkg::DMINFO_ADDR:  o_dbus_resp_data = dm_pkg::DMINFO_VALUE;
        dm_pkg::HALTSUM_ADDR: o_dbus_resp_data = dm_pkg::DBUS_DATA_W'(i_haltnot);
        default:              o_dbus_resp_data = '0;
      endcase
    end
  end

  // RAM request, NOP and read never write
  assign o_ram_access = req_hsk & sel_ram;
  assign o_ram_addr   = i_dbus_req_addr[dm_pkg::RAM_ADDR_W-1:0];
  assign o_ram_read   = (req_op != dm_pkg::DBUS_WRITE);
  assign o_ram_wdata  = i_dbus_req_data[dm_pkg::SYS_DATA_W-1:0];

  // ==========================================================
  // Flag strobes: bit 33 writes 1 to debint, bit 32 writes 0 to haltnot
  // ==========================================================
  assign wr_flags = req_hsk & (req_op == dm_pkg::DBUS_WRITE) &
                    (sel_ram | (i_dbus_req_addr == dm_pkg::DMCONTROL_ADDR));

  always_comb begin
    for (int h = 0; h < HART_NUM; h++) begin
      o_debint_set[h]  = wr_flags & i_dbus_req_data[33] & (hart_id == HART_ID_W'(h));
      o_haltnot_clr[h] = wr_flags & ~i_dbus_req_data[32] & (hart_id == HART_ID_W'(h));
    end
  end

endmodule

`default_nettype wire

// File: design/dm_sysbus_slave.sv
/*
  System bus slave used by the hart's debug code. Zero-cycle response with
  the cleardebint and sethaltnot registers, the debug RAM page and the ROM.
*/
`timescale 1ns/1ns
`default_nettype none

module dm_sysbus_slave #(
  parameter int HART_NUM  = 1,
  parameter int HART_ID_W = 1
) (
  input  wire                           i_clk,
  input  wire                           i_reset,
  input  wire                           i_sys_cmd_valid,
  input  wire [dm_pkg::SYS_ADDR_W-1:0]  i_sys_cmd_addr,
  input  wire                           i_sys_cmd_read,
  input  wire [dm_pkg::SYS_DATA_W-1:0]  i_sys_cmd_wdata,
  input  wire                           i_sys_rsp_ready,
  input  wire [dm_pkg::SYS_DATA_W-1:0]  i_ram_rdata,
  output logic                          o_sys_cmd_ready,
  output logic                          o_sys_rsp_valid,
  output logic [dm_pkg::SYS_DATA_W-1:0] o_sys_rsp_rdata,
  output logic                          o_ram_access,
  output logic [dm_pkg::RAM_ADDR_W-1:0] o_ram_addr,
  output logic                          o_ram_read,
  output logic [dm_pkg::SYS_DATA_W-1:0] o_ram_wdata,
  output logic [HART_NUM-1:0]           o_haltnot_set,
  output logic [HART_NUM-1:0]           o_debint_clr
);

  logic                          cmd_hsk;
  logic                          cmd_wr;
  logic                          sel_cleardebint;
  logic                          sel_sethaltnot;
  logic                          sel_ram;
  logic                          sel_rom;
  logic                          wr_cleardebint;
  logic                          wr_sethaltnot;
  logic [HART_ID_W-1:0]          wr_hart;
  logic [HART_ID_W-1:0]          cleardebint_q;
  logic [HART_ID_W-1:0]          sethaltnot_q;
  logic [dm_pkg::SYS_DATA_W-1:0] rom_word;

  // Pass-through handshake
  assign o_sys_cmd_ready = i_sys_rsp_ready;
  assign o_sys_rsp_valid = i_sys_cmd_valid;
  assign cmd_hsk         = i_sys_cmd_valid & o_sys_cmd_ready;
  assign cmd_wr          = cmd_hsk & ~i_sys_cmd_read;

  // ==========================================================
  // Address decode
  // ==========================================================
  assign sel_cleardebint = (i_sys_cmd_addr == dm_pkg::CLEARDEBINT_ADDR);
  assign sel_sethaltnot  = (i_sys_cmd_addr == dm_pkg::SETHALTNOT_ADDR);
  assign sel_ram         = (i_sys_cmd_addr[11:8] == dm_pkg::RAM_PAGE);
  assign sel_rom         = (i_sys_cmd_addr[11:8] == dm_pkg::ROM_PAGE);

  assign wr_cleardebint = cmd_wr & sel_cleardebint;
  assign wr_sethaltnot  = cmd_wr & sel_sethaltnot;
  assign wr_hart        = i_sys_cmd_wdata[HART_ID_W-1:0];

  // Last hart id written to each register
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      cleardebint_q <= '0;
      sethaltnot_q  <= '0;
    end else begin
      if (wr_cleardebint) begin
        cleardebint_q <= wr_hart;
      end
      if (wr_sethaltnot) begin
        sethaltnot_q <= wr_hart;
      end
    end
  end

  // One pulse for the hart named in the write data
  always_comb begin
    for (int h = 0; h < HART_NUM; h++) begin
      o_haltnot_set[h] = wr_sethaltnot & (wr_hart == HART_ID_W'(h));
      o_debint_clr[h]  = wr_cleardebint & (wr_hart == HART_ID_W'(h));
    end
  end

  // RAM request, word index from bits 4:2
  assign o_ram_access = cmd_hsk & sel_ram;
  assign o_ram_addr   = i_sys_cmd_addr[4:2];
  assign o_ram_read   = i_sys_cmd_read;
  assign o_ram_wdata  = i_sys_cmd_wdata;

  // ROM lookup, writes to this page are dropped
  assign rom_word = dm_pkg::DEBUG_ROM[i_sys_cmd_addr[6:2]];

  // ==========================================================
  // Read data
  // ==========================================================
  always_comb begin
    if (sel_cleardebint) begin
      o_sys_rsp_rdata = dm_pkg::SYS_DATA_W'(cleardebint_q);
    end else if (sel_sethaltnot) begin
      o_sys_rsp_rdata = dm_pkg::SYS_DATA_W'(sethaltnot_q);
    end else if (sel_ram) begin
      o_sys_rsp_rdata = i_ram_rdata;
    end else if (sel_rom) begin
      o_sys_rsp_rdata = rom_word;
    end else begin
      o_sys_rsp_rdata = '0;
    end
  end

endmodule

`default_nettype wire

// File: design/dm_hart_flags.sv
/*
  Per-hart haltnot and debint flags. Set wins over clear in the same cycle.
*/
`timescale 1ns/1ns
`default_nettype none

module dm_hart_flags #(
  parameter int HART_NUM  = 1,
  parameter int HART_ID_W = 1
) (
  input  wire                 i_clk,
  input  wire                 i_reset,
  input  wire  [HART_NUM-1:0] i_haltnot_set,
  input  wire  [HART_NUM-1:0] i_haltnot_clr,
  input  wire  [HART_NUM-1:0] i_debint_set,
  input  wire  [HART_NUM-1:0] i_debint_clr,
  output logic [HART_NUM-1:0] o_haltnot,
  output logic [HART_NUM-1:0] o_debint
);

  // Hart ids must be able to name every hart
  localparam int HART_SLOTS = 2**HART_ID_W;

  for (genvar g = 0; g < HART_NUM; g++) begin : g_hart
    logic haltnot_q;
    logic debint_q;

    always_ff @(posedge i_clk) begin
      if (i_reset || g >= HART_SLOTS) begin
        haltnot_q <= 1'b0;
        debint_q  <= 1'b0;
      end else begin
        if (i_haltnot_set[g]) begin
          haltnot_q <= 1'b1;
        end else if (i_haltnot_clr[g]) begin
          haltnot_q <= 1'b0;
        end
        if (i_debint_set[g]) begin
          debint_q <= 1'b1;
        end else if (i_debint_clr[g]) begin
          debint_q <= 1'b0;
        end
      end
    end

    assign o_haltnot[g] = haltnot_q;
    assign o_debint[g]  = debint_q;
  end

endmodule

`default_nettype wire

// File: design/dm_debug_ram.sv
/*
  Seven-word debug RAM shared by both buses. The system bus wins a clash;
  reads are combinational from the selected address.
*/
`timescale 1ns/1ns
`default_nettype none

module dm_debug_ram (
  input  wire                           i_clk,
  input  wire                           i_reset,
  input  wire                           i_sys_access,
  input  wire  [dm_pkg::RAM_ADDR_W-1:0] i_sys_addr,
  input  wire                           i_sys_read,
  input  wire  [dm_pkg::SYS_DATA_W-1:0] i_sys_wdata,
  input  wire                           i_dbus_access,
  input  wire  [dm_pkg::RAM_ADDR_W-1:0] i_dbus_addr,
  input  wire                           i_dbus_read,
  input  wire  [dm_pkg::SYS_DATA_W-1:0] i_dbus_wdata,
  output logic [dm_pkg::SYS_DATA_W-1:0] o_rdata
);

  logic [dm_pkg::SYS_DATA_W-1:0] mem [dm_pkg::RAM_WORDS];
  logic [dm_pkg::RAM_ADDR_W-1:0] addr;
  logic                          wr_en;
  logic [dm_pkg::SYS_DATA_W-1:0] wdata;
  logic                          addr_ok;

  // Port select
  assign addr    = i_sys_access ? i_sys_addr : i_dbus_addr;
  assign wdata   = i_sys_access ? i_sys_wdata : i_dbus_wdata;
  assign wr_en   = i_sys_access ? ~i_sys_read : (i_dbus_access & ~i_dbus_read);
  assign addr_ok = (addr < dm_pkg::RAM_ADDR_W'(dm_pkg::RAM_WORDS));

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      for (int w = 0; w < dm_pkg::RAM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (wr_en && addr_ok) begin
      mem[addr] <= wdata;
    end
  end

  // Word 7 is not backed and reads as zero
  assign o_rdata = addr_ok ? mem[addr] : '0;

endmodule

`default_nettype wire

// File: design/debug_module_top.sv
/*
  Debug module top level. Wires the debug bus slave, the system bus slave,
  the hart flags and the shared debug RAM together.
*/
`timescale 1ns/1ns
`default_nettype none

module debug_module_top #(
  parameter int HART_NUM  = 1,
  parameter int HART_ID_W = 1
) (
  input  wire                           i_clk,
  input  wire                           i_reset,
  // Debug bus
  input  wire                           i_dbus_req_valid,
  input  wire [dm_pkg::DBUS_ADDR_W-1:0] i_dbus_req_addr,
  input  wire [dm_pkg::DBUS_DATA_W-1:0] i_dbus_req_data,
  input  wire [1:0]                     i_dbus_req_op,
  input  wire                           i_dbus_resp_ready,
  output logic                          o_dbus_req_ready,
  output logic                          o_dbus_resp_valid,
  output logic [dm_pkg::DBUS_DATA_W-1:0] o_dbus_resp_data,
  // System bus
  input  wire                           i_sys_cmd_valid,
  input  wire [dm_pkg::SYS_ADDR_W-1:0]  i_sys_cmd_addr,
  input  wire                           i_sys_cmd_read,
  input  wire [dm_pkg::SYS_DATA_W-1:0]  i_sys_cmd_wdata,
  input  wire                           i_sys_rsp_ready,
  output logic                          o_sys_cmd_ready,
  output logic                          o_sys_rsp_valid,
  output logic [dm_pkg::SYS_DATA_W-1:0] o_sys_rsp_rdata,
  // Debug interrupt per hart
  output logic [HART_NUM-1:0]           o_dbg_irq
);

  logic                          sys_ram_access;
  logic [dm_pkg::RAM_ADDR_W-1:0] sys_ram_addr;
  logic                          sys_ram_read;
  logic [dm_pkg::SYS_DATA_W-1:0] sys_ram_wdata;
  logic                          dbus_ram_access;
  logic [dm_pkg::RAM_ADDR_W-1:0] dbus_ram_addr;
  logic                          dbus_ram_read;
  logic [dm_pkg::SYS_DATA_W-1:0] dbus_ram_wdata;
  logic [dm_pkg::SYS_DATA_W-1:0] ram_rdata;
  logic [HART_NUM-1:0]           haltnot_set;
  logic [HART_NUM-1:0]           haltnot_clr;
  logic [HART_NUM-1:0]           debint_set;
  logic [HART_NUM-1:0]           debint_clr;
  logic [HART_NUM-1:0]           haltnot;
  logic [HART_NUM-1:0]           debint;

  dm_dbus_slave #(.HART_NUM(HART_NUM), .HART_ID_W(HART_ID_W)) u_dbus_slave (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_dbus_req_valid(i_dbus_req_valid), .i_dbus_req_addr(i_dbus_req_addr),
    .i_dbus_req_data(i_dbus_req_data), .i_dbus_req_op(i_dbus_req_op),
    .i_dbus_resp_ready(i_dbus_resp_ready), .i_sys_ram_access(sys_ram_access),
    .i_ram_rdata(ram_rdata), .i_haltnot(haltnot), .i_debint(debint),
    .o_dbus_req_ready(o_dbus_req_ready), .o_dbus_resp_valid(o_dbus_resp_valid),
    .o_dbus_resp_data(o_dbus_resp_data),
    .o_ram_access(dbus_ram_access), .o_ram_addr(dbus_ram_addr),
    .o_ram_read(dbus_ram_read), .o_ram_wdata(dbus_ram_wdata),
    .o_haltnot_clr(haltnot_clr), .o_debint_set(debint_set)
  );

  dm_sysbus_slave #(.HART_NUM(HART_NUM), .HART_ID_W(HART_ID_W)) u_sysbus_slave (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_sys_cmd_valid(i_sys_cmd_valid), .i_sys_cmd_addr(i_sys_cmd_addr),
    .i_sys_cmd_read(i_sys_cmd_read), .i_sys_cmd_wdata(i_sys_cmd_wdata),
    .i_sys_rsp_ready(i_sys_rsp_ready), .i_ram_rdata(ram_rdata),
    .o_sys_cmd_ready(o_sys_cmd_ready), .o_sys_rsp_valid(o_sys_rsp_valid),
    .o_sys_rsp_rdata(o_sys_rsp_rdata),
    .o_ram_access(sys_ram_access), .o_ram_addr(sys_ram_addr),
    .o_ram_read(sys_ram_read), .o_ram_wdata(sys_ram_wdata),
    .o_haltnot_set(haltnot_set), .o_debint_clr(debint_clr)
  );

  dm_hart_flags #(.HART_NUM(HART_NUM), .HART_ID_W(HART_ID_W)) u_hart_flags (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_haltnot_set(haltnot_set), .i_haltnot_clr(haltnot_clr),
    .i_debint_set(debint_set), .i_debint_clr(debint_clr),
    .o_haltnot(haltnot), .o_debint(debint)
  );

  dm_debug_ram u_debug_ram (
    .i_clk(i_clk), .i_reset(i_reset),
    .i_sys_access(sys_ram_access), .i_sys_addr(sys_ram_addr),
    .i_sys_read(sys_ram_read), .i_sys_wdata(sys_ram_wdata),
    .i_dbus_access(dbus_ram_access), .i_dbus_addr(dbus_ram_addr),
    .i_dbus_read(dbus_ram_read), .i_dbus_wdata(dbus_ram_wdata),
    .o_rdata(ram_rdata)
  );

  assign o_dbg_irq = debint;

endmodule

`default_nettype wire

// File: verification/tb_clock_gen.sv
/*
  Free-running testbench clock. The period is set by parameter.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS = 20
) (
  output logic o_clk
);

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

// File: verification/tb_debug_module.sv
/*
  Testbench for the debug module top level. Drives both buses, keeps a reference
  model of RAM, hart select and flags, and checks all outputs with assertions.
*/
`timescale 1ns/1ns
`default_nettype none

module tb_debug_module;

  localparam int RAM_WRITES = 20;
  localparam int ROUNDS     = 4;
  localparam int BP_HOLD    = 6;
  // Transfers issued by the sections below
  localparam int NUM_OPS    = RAM_WRITES + 9 + 7 * 4 + 3 * 2 + 34 + 2 + ROUNDS * 5 +
                              ROUNDS * 6 + 4;
  localparam int WATCHDOG_CYCLES = NUM_OPS * 4 + 100;
  // dramsize 6, authenticated, version 1
  localparam logic [33:0] DMINFO_EXP = (34'd6 << 10) | (34'd1 << 5) | 34'd1;

  logic        clk;
  logic        reset;
  logic        dbus_req_valid;
  logic [4:0]  dbus_req_addr;
  logic [33:0] dbus_req_data;
  logic [1:0]  dbus_req_op;
  logic        dbus_resp_ready;
  logic        dbus_req_ready;
  logic        dbus_resp_valid;
  logic [33:0] dbus_resp_data;
  logic        sys_cmd_valid;
  logic [11:0] sys_cmd_addr;
  logic        sys_cmd_read;
  logic [31:0] sys_cmd_wdata;
  logic        sys_rsp_ready;
  logic        sys_cmd_ready;
  logic        sys_rsp_valid;
  logic [31:0] sys_rsp_rdata;
  logic [1:0]  dbg_irq;

  // Reference model state
  logic [31:0] ram_m [0:6];
  logic        hart_m;
  logic [1:0]  haltnot_m;
  logic [1:0]  debint_m;
  logic        clrdebint_m;
  logic        sethalt_m;

  logic        sys_ram_acc;
  logic        sys_acc;
  logic        dbus_acc;
  logic        flag_wr;
  logic [1:0]  hart_bit;
  logic [1:0]  haltnot_set_m;
  logic [1:0]  haltnot_clr_m;
  logic [1:0]  debint_set_m;
  logic [1:0]  debint_clr_m;
  logic        exp_dbus_ready;
  logic        exp_dbus_valid;
  logic [33:0] exp_dbus_data;
  logic [31:0] exp_sys_rdata;

  logic [31:0] rng_state = 32'hb419ae9d;
  int          errors = 0;
  int          num_ops = 0;

  tb_clock_gen #(.PERIOD_NS(20)) u_clock_gen (.o_clk(clk));

  debug_module_top #(.HART_NUM(2), .HART_ID_W(1)) dut0 (
    .i_clk(clk), .i_reset(reset),
    .i_dbus_req_valid(dbus_req_valid), .i_dbus_req_addr(dbus_req_addr),
    .i_dbus_req_data(dbus_req_data), .i_dbus_req_op(dbus_req_op),
    .i_dbus_resp_ready(dbus_resp_ready), .o_dbus_req_ready(dbus_req_ready),
    .o_dbus_resp_valid(dbus_resp_valid), .o_dbus_resp_data(dbus_resp_data),
    .i_sys_cmd_valid(sys_cmd_valid), .i_sys_cmd_addr(sys_cmd_addr),
    .i_sys_cmd_read(sys_cmd_read), .i_sys_cmd_wdata(sys_cmd_wdata),
    .i_sys_rsp_ready(sys_rsp_ready), .o_sys_cmd_ready(sys_cmd_ready),
    .o_sys_rsp_valid(sys_rsp_valid), .o_sys_rsp_rdata(sys_rsp_rdata),
    .o_dbg_irq(dbg_irq)
  );

  // ============================================================
  // Reference model
  // ============================================================
  assign sys_acc        = sys_cmd_valid & sys_rsp_ready;
  assign sys_ram_acc    = sys_acc & (sys_cmd_addr[11:8] == dm_pkg::RAM_PAGE);
  assign exp_dbus_ready = dbus_resp_ready & ~((dbus_req_addr < 5'd7) & sys_ram_acc);
  assign exp_dbus_valid = dbus_req_valid & ~((dbus_req_addr < 5'd7) & sys_ram_acc);
  assign dbus_acc       = dbus_req_valid & exp_dbus_ready;
  assign flag_wr        = dbus_acc && dbus_req_op == dm_pkg::DBUS_WRITE &&
                          (dbus_req_addr < 5'd7 || dbus_req_addr == dm_pkg::DMCONTROL_ADDR);
  assign hart_bit       = 2'b01 << hart_m;
  assign debint_set_m   = (flag_wr && dbus_req_data[33]) ? hart_bit : 2'b00;
  assign haltnot_clr_m  = (flag_wr && !dbus_req_data[32]) ? hart_bit : 2'b00;
  assign haltnot_set_m  = (sys_acc && !sys_cmd_read &&
                           sys_cmd_addr == dm_pkg::SETHALTNOT_ADDR) ?
                          (2'b01 << sys_cmd_wdata[0]) : 2'b00;
  assign debint_clr_m   = (sys_acc && !sys_cmd_read &&
                           sys_cmd_addr == dm_pkg::CLEARDEBINT_ADDR) ?
                          (2'b01 << sys_cmd_wdata[0]) : 2'b00;

  always_comb begin
    if (dbus_req_addr < 5'd7) begin
      exp_dbus_data = {debint_m[hart_m], haltnot_m[hart_m], ram_m[dbus_req_addr[2:0]]};
    end else begin
      case (dbus_req_addr)
        dm_pkg::DMCONTROL_ADDR:
          exp_dbus_data = {debint_m[hart_m], haltnot_m[hart_m], 29'b0, hart_m, 2'b0};
        dm_pkg::DMINFO_ADDR:  exp_dbus_data = DMINFO_EXP;
        dm_pkg::HALTSUM_ADDR: exp_dbus_data = {32'b0, haltnot_m};
        default:              exp_dbus_data = '0;
      endcase
    end
  end

  always_comb begin
    if (sys_cmd_addr == dm_pkg::CLEARDEBINT_ADDR) begin
      exp_sys_rdata = {31'b0, clrdebint_m};
    end else if (sys_cmd_addr == dm_pkg::SETHALTNOT_ADDR) begin
      exp_sys_rdata = {31'b0, sethalt_m};
    end else if (sys_cmd_addr[11:8] == dm_pkg::RAM_PAGE) begin
      exp_sys_rdata = (sys_cmd_addr[4:2] < 3'd7) ? ram_m[sys_cmd_addr[4:2]] : '0;
    end else if (sys_cmd_addr[11:8] == dm_pkg::ROM_PAGE) begin
      exp_sys_rdata = dm_pkg::DEBUG_ROM[sys_cmd_addr[6:2]];
    end else begin
      exp_sys_rdata = '0;
    end
  end

  always @(posedge clk) begin
    if (reset) begin
      for (int w = 0; w < 7; w++) begin
        ram_m[w] <= '0;
      end
      hart_m      <= 1'b0;
      haltnot_m   <= '0;
      debint_m    <= '0;
      clrdebint_m <= 1'b0;
      sethalt_m   <= 1'b0;
    end else begin
      if (sys_acc && !sys_cmd_read) begin
        if (sys_cmd_addr == dm_pkg::CLEARDEBINT_ADDR) begin
          clrdebint_m <= sys_cmd_wdata[0];
        end
        if (sys_cmd_addr == dm_pkg::SETHALTNOT_ADDR) begin
          sethalt_m <= sys_cmd_wdata[0];
        end
        if (sys_ram_acc && sys_cmd_addr[4:2] < 3'd7) begin
          ram_m[sys_cmd_addr[4:2]] <= sys_cmd_wdata;
        end
      end
      if (dbus_acc && dbus_req_op == dm_pkg::DBUS_WRITE) begin
        if (dbus_req_addr == dm_pkg::DMCONTROL_ADDR) begin
          hart_m <= dbus_req_data[2];
        end
        if (dbus_req_addr < 5'd7) begin
          ram_m[dbus_req_addr[2:0]] <= dbus_req_data[31:0];
        end
      end
      // Set beats clear
      haltnot_m <= (haltnot_m & ~haltnot_clr_m) | haltnot_set_m;
      debint_m  <= (debint_m & ~debint_clr_m) | debint_set_m;
    end
  end

  // ============================================================
  // Assertions
  // ============================================================
  a_dbus_hsk: assert property (@(posedge clk) disable iff (reset)
    dbus_req_ready == exp_dbus_ready && dbus_resp_valid == exp_dbus_valid)
    else begin
      errors++;
      $display("[ERROR] %0t: debug bus ready/valid %b/%b, expected %b/%b", $time,
               $sampled(dbus_req_ready), $sampled(dbus_resp_valid),
               $sampled(exp_dbus_ready), $sampled(exp_dbus_valid));
    end

  a_dbus_data: assert property (@(posedge clk) disable iff (reset)
    exp_dbus_valid |-> dbus_resp_data == exp_dbus_data)
    else begin
      errors++;
      $display("[ERROR] %0t: debug bus addr %h read %h, expected %h", $time,
               $sampled(dbus_req_addr), $sampled(dbus_resp_data), $sampled(exp_dbus_data));
    end

  a_sys_hsk: assert property (@(posedge clk) disable iff (reset)
    sys_cmd_ready == sys_rsp_ready && sys_rsp_valid == sys_cmd_valid)
    else begin
      errors++;
      $display("[ERROR] %0t: system bus ready/valid %b/%b do not follow inputs", $time,
               $sampled(sys_cmd_ready), $sampled(sys_rsp_valid));
    end

  a_sys_data: assert property (@(posedge clk) disable iff (reset)
    sys_acc |-> sys_rsp_rdata == exp_sys_rdata)
    else begin
      errors++;
      $display("[ERROR] %0t: system bus addr %h read %h, expected %h", $time,
               $sampled(sys_cmd_addr), $sampled(sys_rsp_rdata), $sampled(exp_sys_rdata));
    end

  a_irq: assert property (@(posedge clk) disable iff (reset) dbg_irq == debint_m)
    else begin
      errors++;
      $display("[ERROR] %0t: debug interrupt %b, expected %b", $time,
               $sampled(dbg_irq), $sampled(debint_m));
    end

  // ============================================================
  // Stimulus helpers
  // ============================================================
  function automatic logic [31:0] xorshift32();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  function automatic logic [33:0] rand_dbus_data();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = xorshift32();
    lo = xorshift32();
    return {hi[1:0], lo};
  endfunction

  // Cycles of low response ready before a transfer
  function automatic int pick_hold();
    logic [31:0] r;
    r = xorshift32();
    return int'(r % 3);
  endfunction

  function automatic logic [11:0] ram_sys_addr(input logic [2:0] word);
    return {dm_pkg::RAM_PAGE, 3'b0, word, 2'b0};
  endfunction

  task automatic dbus_xfer(input logic [1:0] op, input logic [4:0] addr,
                           input logic [33:0] data, input int hold);
    dbus_req_valid  <= 1'b1;
    dbus_req_op     <= op;
    dbus_req_addr   <= addr;
    dbus_req_data   <= data;
    dbus_resp_ready <= (hold == 0);
    repeat (hold) @(posedge clk);
    dbus_resp_ready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!dbus_req_ready);
    dbus_req_valid <= 1'b0;
    num_ops++;
  endtask

  task automatic sys_xfer(input logic rd, input logic [11:0] addr,
                          input logic [31:0] wdata, input int hold);
    sys_cmd_valid <= 1'b1;
    sys_cmd_read  <= rd;
    sys_cmd_addr  <= addr;
    sys_cmd_wdata <= wdata;
    sys_rsp_ready <= (hold == 0);
    repeat (hold) @(posedge clk);
    sys_rsp_ready <= 1'b1;
    do begin
      @(posedge clk);
    end while (!sys_cmd_ready);
    sys_cmd_valid <= 1'b0;
    num_ops++;
  endtask

  // Both buses hit the RAM in the same cycle and the system bus goes first
  task automatic ram_clash(input logic [2:0] word, input logic [31:0] wdata);
    dbus_req_valid  <= 1'b1;
    dbus_req_op     <= dm_pkg::DBUS_READ;
    dbus_req_addr   <= {2'b0, word};
    dbus_req_data   <= '0;
    dbus_resp_ready <= 1'b1;
    sys_cmd_valid   <= 1'b1;
    sys_cmd_read    <= 1'b0;
    sys_cmd_addr    <= ram_sys_addr(word);
    sys_cmd_wdata   <= wdata;
    sys_rsp_ready   <= 1'b1;
    do begin
      @(posedge clk);
    end while (!sys_cmd_ready);
    sys_cmd_valid <= 1'b0;
    do begin
      @(posedge clk);
    end while (!dbus_req_ready);
    dbus_req_valid <= 1'b0;
    num_ops += 2;
  endtask

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    logic [31:0] r;
    logic        h;
    reset           <= 1'b1;
    dbus_req_valid  <= 1'b0;
    dbus_req_addr   <= '0;
    dbus_req_data   <= '0;
    dbus_req_op     <= dm_pkg::DBUS_NOP;
    dbus_resp_ready <= 1'b1;
    sys_cmd_valid   <= 1'b0;
    sys_cmd_addr    <= '0;
    sys_cmd_read    <= 1'b1;
    sys_cmd_wdata   <= '0;
    sys_rsp_ready   <= 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;

    // RAM, dminfo and an unused address over the debug bus
    repeat (RAM_WRITES) begin
      r = xorshift32();
      dbus_xfer(dm_pkg::DBUS_WRITE, {2'b0, 3'(r % 7)}, rand_dbus_data(), pick_hold());
    end
    for (int w = 0; w < 7; w++) begin
      dbus_xfer(dm_pkg::DBUS_READ, 5'(w), '0, pick_hold());
    end
    dbus_xfer(dm_pkg::DBUS_READ, dm_pkg::DMINFO_ADDR, '0, pick_hold());
    dbus_xfer(dm_pkg::DBUS_READ, 5'h0A, '0, pick_hold());

    // RAM shared between the buses
    for (int w = 0; w < 7; w++) begin
      sys_xfer(1'b0, ram_sys_addr(3'(w)), xorshift32(), pick_hold());
      dbus_xfer(dm_pkg::DBUS_READ, 5'(w), '0, pick_hold());
      dbus_xfer(dm_pkg::DBUS_WRITE, 5'(w), rand_dbus_data(), pick_hold());
      sys_xfer(1'b1, ram_sys_addr(3'(w)), '0, pick_hold());
    end
    repeat (3) begin
      r = xorshift32();
      ram_clash(3'(r % 7), xorshift32());
    end

    // ROM reads and a write that must be dropped
    for (int i = 0; i < 32; i++) begin
      sys_xfer(1'b1, {dm_pkg::ROM_PAGE, 1'b0, 5'(i), 2'b0}, '0, pick_hold());
    end
    sys_xfer(1'b0, {dm_pkg::ROM_PAGE, 8'h0C}, xorshift32(), pick_hold());
    sys_xfer(1'b1, {dm_pkg::ROM_PAGE, 8'h0C}, '0, pick_hold());

    // Debug interrupt raise and clear
    sys_xfer(1'b0, dm_pkg::CLEARDEBINT_ADDR, 32'd0, 0);
    sys_xfer(1'b0, dm_pkg::CLEARDEBINT_ADDR, 32'd1, 0);
    repeat (ROUNDS) begin
      r = xorshift32();
      h = r[3];
      dbus_xfer(dm_pkg::DBUS_WRITE, dm_pkg::DMCONTROL_ADDR, {2'b01, 29'b0, h, 2'b0},
                pick_hold());
      dbus_xfer(dm_pkg::DBUS_WRITE, {2'b0, 3'(r % 7)}, {2'b11, xorshift32()}, pick_hold());
      dbus_xfer(dm_pkg::DBUS_READ, dm_pkg::DMCONTROL_ADDR, '0, pick_hold());
      sys_xfer(1'b0, dm_pkg::CLEARDEBINT_ADDR, {r[31:1], h}, pick_hold());
      sys_xfer(1'b1, dm_pkg::CLEARDEBINT_ADDR, '0, pick_hold());
    end

    // Halt notification set and clear
    repeat (ROUNDS) begin
      r = xorshift32();
      h = r[7];
      sys_xfer(1'b0, dm_pkg::SETHALTNOT_ADDR, {r[31:1], h}, pick_hold());
      dbus_xfer(dm_pkg::DBUS_READ, dm_pkg::HALTSUM_ADDR, '0, pick_hold());
      dbus_xfer(dm_pkg::DBUS_WRITE, dm_pkg::DMCONTROL_ADDR, {2'b01, 29'b0, h, 2'b0},
                pick_hold());
      dbus_xfer(dm_pkg::DBUS_READ, dm_pkg::DMCONTROL_ADDR, '0, pick_hold());
      dbus_xfer(dm_pkg::DBUS_WRITE, dm_pkg::DMCONTROL_ADDR, {2'b00, 29'b0, h, 2'b0},
                pick_hold());
      dbus_xfer(dm_pkg::DBUS_READ, dm_pkg::HALTSUM_ADDR, '0, pick_hold());
    end

    // Long back-pressure on each bus
    dbus_xfer(dm_pkg::DBUS_WRITE, 5'd2, rand_dbus_data(), BP_HOLD);
    dbus_xfer(dm_pkg::DBUS_READ, 5'd2, '0, 0);
    sys_xfer(1'b0, ram_sys_addr(3'd5), xorshift32(), BP_HOLD);
    sys_xfer(1'b1, ram_sys_addr(3'd5), '0, 0);

    repeat (2) @(posedge clk);
    $display("Transfers %0d, errors %0d", num_ops, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("Timeout: no handshake within %0d cycles, %0d transfers done, %0d errors",
             WATCHDOG_CYCLES, num_ops, errors);
    $display("Test failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
design/dm_pkg.sv
design/dm_dbus_slave.sv
design/dm_sysbus_slave.sv
design/dm_hart_flags.sv
design/dm_debug_ram.sv
design/debug_module_top.sv
verification/tb_clock_gen.sv
verification/tb_debug_module.sv

// File: Makefile
# Verilator build and run of the debug module testbench

VERILATOR ?= verilator
TOP       ?= tb_debug_module
LOG       ?= sim.log
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP LOG FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "No pass line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
